// File: design/mdll_pkg.sv
/*
 * shared definitions for the coarse frequency calibration loop
 * count and code width defaults, controller state type
 */
`default_nettype none

package mdll_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------

	localparam int N_FCAL_CNT = 12;                 // feedback count width
	localparam int N_NDIV     = $clog2(N_FCAL_CNT); // width of fcal_ndiv_ref
	localparam int N_CODE     = 6;                  // coarse oscillator code width

	// --------------------------------------------------
	// calibration controller states
	// --------------------------------------------------

	typedef enum logic [2:0] {
		IDLE    = 3'd0, // waiting for cal_start
		TRIAL   = 3'd1, // new trial code settles
		MEAS    = 3'd2, // request held, waiting for ready
		DECIDE  = 3'd3, // sar applies the compare
		RELEASE = 3'd4, // request dropped, waiting for ready low
		DONE    = 3'd5  // one-cycle done strobe
	} fcal_state_t;

endpackage

`default_nettype wire

// File: design/mdll_synchronizer.sv
/*
 * multi-flop synchronizer on clk_fb
 * all flop taps exposed for edge detection
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_synchronizer #(
	parameter int DEPTH = 2 // number of flops, at least 2
) (
	input  wire              clk_fb,
	input  wire              rst_n,
	input  wire              din,   // asynchronous input
	output logic             dout,  // synchronized level
	output logic [DEPTH-1:0] din_d  // tap 0 is the newest sample
);

	// shift chain, newest sample enters at bit 0
	always_ff @(posedge clk_fb) begin
		if (!rst_n) begin
			din_d <= '0;
		end else begin
			din_d <= {din_d[DEPTH-2:0], din};
		end
	end

	// last tap is the settled copy
	assign dout = din_d[DEPTH-1];

endmodule

`default_nettype wire

// File: design/mdll_freq_div_radix2.sv
/*
 * free-running radix-2 divider on the reference clock
 * ripple-carry binary counter, every bit is a divided tap
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_freq_div_radix2 #(
	parameter int WIDTH = 16 // number of divided taps
) (
	input  wire              clk_refp, // reference clock
	output logic [WIDTH-1:0] cntr      // bit k is high for 2**k ref cycles
);

	logic [WIDTH:0] carry; // carry into each stage

	// stage 0 toggles every cycle
	assign carry[0] = 1'b1;

	// --------------------------------------------------
	// toggle stages
	// --------------------------------------------------

	for (genvar k = 0; k < WIDTH; k++) begin : g_stage
		// next stage toggles once all lower bits are high
		assign carry[k+1] = carry[k] & cntr[k];

		// toggle flop of stage k
		always_ff @(posedge clk_refp) begin
			cntr[k] <= cntr[k] ^ carry[k];
		end
	end

endmodule

`default_nettype wire

// File: design/mdll_fcal_counter.sv
/*
 * feedback clock counter for coarse frequency calibration
 * reference pulse divider, pulse synchronizer, armed high-time count
 * count latch and ready acknowledge toward the controller
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_fcal_counter #(
	parameter int P_CNT_W = mdll_pkg::N_FCAL_CNT
) (
	input  wire                        clk_fb,        // feedback clock
	input  wire                        rst_n,
	input  wire                        clk_refp,      // accurate reference clock
	input  wire                        fcal_en,       // synced enable
	input  wire                        fcal_start,    // request level
	input  wire [mdll_pkg::N_NDIV-1:0] fcal_ndiv_ref, // ref pulse is 2**ndiv ref cycles
	output logic [P_CNT_W-1:0]         fcal_cnt,      // latched high-time count
	output logic                       fcal_ready     // acknowledge level
);

	import mdll_pkg::*;

	localparam int DIV_W = 2 ** N_NDIV; // one tap per ndiv value

	logic [DIV_W-1:0]   ref_taps;    // divided reference clocks
	logic               ref_pulse;   // selected tap
	logic [2:0]         ref_pulse_d; // synced samples, bit 2 oldest
	logic               ref_rise;
	logic               ref_fall;
	logic               armed;       // a rise was seen during this request
	logic [P_CNT_W-1:0] fb_cnt;      // running high-time count

	// --------------------------------------------------
	// reference pulse
	// --------------------------------------------------

	mdll_freq_div_radix2 #(.WIDTH(DIV_W)) i_ref_div (
		.clk_refp (clk_refp),
		.cntr     (ref_taps)
	);

	assign ref_pulse = ref_taps[fcal_ndiv_ref];

	// pulse into the feedback domain
	mdll_synchronizer #(.DEPTH(3)) i_ref_sync (
		.clk_fb (clk_fb),
		.rst_n  (rst_n),
		.din    (ref_pulse),
		.dout   (),
		.din_d  (ref_pulse_d)
	);

	assign ref_rise = (ref_pulse_d[2:1] == 2'b01);
	assign ref_fall = (ref_pulse_d[2:1] == 2'b10);

	// --------------------------------------------------
	// counting
	// --------------------------------------------------

	// restarts on every reference rise
	always_ff @(posedge clk_fb) begin
		if (!rst_n || ref_rise) begin
			fb_cnt <= '0;
		end else begin
			fb_cnt <= fb_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_fb) begin
		if (!rst_n || !fcal_en) begin
			armed      <= 1'b0;
			fcal_ready <= 1'b0;
			fcal_cnt   <= '0;
		end else if (!fcal_start) begin
			armed      <= 1'b0; // request gone
			fcal_ready <= 1'b0; // drop the acknowledge
		end else if (armed && ref_fall) begin
			armed      <= 1'b0;
			fcal_ready <= 1'b1;
			fcal_cnt   <= fb_cnt + 1'b1; // includes the rise cycle
		end else if (!fcal_ready && ref_rise) begin
			armed <= 1'b1; // a fall before this is ignored
		end
	end

endmodule

`default_nettype wire

// File: design/mdll_fcal_sar.sv
/*
 * successive-approximation register for the coarse code
 * one-hot trial pointer, count against target compare
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_fcal_sar #(
	parameter int P_CNT_W  = mdll_pkg::N_FCAL_CNT,
	parameter int P_CODE_W = mdll_pkg::N_CODE
) (
	input  wire                 clk_fb,
	input  wire                 rst_n,
	input  wire                 sar_init,    // load the msb trial
	input  wire                 sar_decide,  // apply compare, step down one bit
	input  wire [P_CNT_W-1:0]   fcal_cnt,    // measured count for the trial code
	input  wire [P_CNT_W-1:0]   fcal_target, // largest allowed count
	output logic [P_CODE_W-1:0] cal_code,    // trial or final code
	output logic                sar_last     // trial pointer at bit 0
);

	localparam logic [P_CODE_W-1:0] MSB_ONLY = {1'b1, {(P_CODE_W-1){1'b0}}};

	logic [P_CODE_W-1:0] trial;     // one-hot bit under test
	logic                keep;      // trial bit survives
	logic [P_CODE_W-1:0] code_next;

	// --------------------------------------------------
	// decision
	// --------------------------------------------------

	// oscillator too slow when the count is above target
	assign keep = (fcal_cnt <= fcal_target);

	always_comb begin
		code_next = cal_code;
		if (!keep) begin
			code_next = code_next & ~trial; // clear rejected bit
		end
		code_next = code_next | (trial >> 1); // set next trial bit
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------

	always_ff @(posedge clk_fb) begin
		if (!rst_n) begin
			cal_code <= '0;
			trial    <= '0;
		end else if (sar_init) begin
			cal_code <= MSB_ONLY;
			trial    <= MSB_ONLY;
		end else if (sar_decide) begin
			cal_code <= code_next;
			trial    <= trial >> 1; // empty after bit 0
		end
	end

	assign sar_last = trial[0];

endmodule

`default_nettype wire

// File: design/mdll_fcal_ctrl.sv
/*
 * coarse calibration sequencer
 * enable synchronizer, measurement handshake, sar stepping
 * abort on enable loss and the done strobe
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_fcal_ctrl (
	input  wire  clk_fb,
	input  wire  rst_n,
	input  wire  en_fcal,    // asynchronous enable level
	input  wire  cal_start,  // one-cycle start strobe
	input  wire  fcal_ready, // counter acknowledge
	input  wire  sar_last,   // sar is on bit 0
	output logic fcal_en,    // synced enable to the counter
	output logic fcal_start, // measurement request
	output logic sar_init,
	output logic sar_decide,
	output logic cal_busy,
	output logic cal_done
);

	import mdll_pkg::*;

	fcal_state_t state;
	fcal_state_t state_nxt;
	logic        en_sync;
	logic        last_q; // the bit just decided was bit 0

	mdll_synchronizer #(.DEPTH(2)) i_en_sync (
		.clk_fb (clk_fb),
		.rst_n  (rst_n),
		.din    (en_fcal),
		.dout   (en_sync),
		.din_d  ()
	);

	assign fcal_en = en_sync;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (sar_init) state_nxt = TRIAL;
			TRIAL:   if (!fcal_ready) state_nxt = MEAS;  // previous ack gone
			MEAS:    if (fcal_ready) state_nxt = DECIDE;
			DECIDE:  state_nxt = RELEASE;
			RELEASE: begin
				if (!fcal_ready) begin
					state_nxt = last_q ? DONE : TRIAL;
				end
			end
			DONE:    state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
		if (!en_sync) begin
			state_nxt = IDLE; // abort, no done strobe
		end
	end

	always_ff @(posedge clk_fb) begin
		if (!rst_n) begin
			state  <= IDLE;
			last_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (sar_decide) begin
				last_q <= sar_last;
			end
		end
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------

	assign sar_init   = (state == IDLE) && cal_start && en_sync; // busy ignores start
	assign sar_decide = (state == DECIDE);
	assign fcal_start = (state == MEAS) || (state == DECIDE);    // held until ready seen
	assign cal_busy   = (state != IDLE) && (state != DONE);
	assign cal_done   = (state == DONE);

endmodule

`default_nettype wire

// File: design/mdll_fcal_top.sv
/*
 * coarse frequency calibration loop top level
 * controller, feedback counter and sar wired together
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_fcal_top #(
	parameter int P_CNT_W  = mdll_pkg::N_FCAL_CNT,
	parameter int P_CODE_W = mdll_pkg::N_CODE
) (
	input  wire                        clk_fb,
	input  wire                        rst_n,
	input  wire                        clk_refp,
	input  wire                        en_fcal,
	input  wire                        cal_start,
	input  wire [mdll_pkg::N_NDIV-1:0] fcal_ndiv_ref,
	input  wire [P_CNT_W-1:0]          fcal_target,
	output logic [P_CODE_W-1:0]        cal_code,
	output logic                       cal_busy,
	output logic                       cal_done,
	output logic [P_CNT_W-1:0]         fcal_cnt,
	output logic                       fcal_ready
);

	logic fcal_en;    // synced enable
	logic fcal_start; // measurement request
	logic sar_init;
	logic sar_decide;
	logic sar_last;

	mdll_fcal_ctrl i_ctrl (
		.clk_fb     (clk_fb),
		.rst_n      (rst_n),
		.en_fcal    (en_fcal),
		.cal_start  (cal_start),
		.fcal_ready (fcal_ready),
		.sar_last   (sar_last),
		.fcal_en    (fcal_en),
		.fcal_start (fcal_start),
		.sar_init   (sar_init),
		.sar_decide (sar_decide),
		.cal_busy   (cal_busy),
		.cal_done   (cal_done)
	);

	mdll_fcal_counter #(.P_CNT_W(P_CNT_W)) i_counter (
		.clk_fb        (clk_fb),
		.rst_n         (rst_n),
		.clk_refp      (clk_refp),
		.fcal_en       (fcal_en),
		.fcal_start    (fcal_start),
		.fcal_ndiv_ref (fcal_ndiv_ref),
		.fcal_cnt      (fcal_cnt),
		.fcal_ready    (fcal_ready)
	);

	mdll_fcal_sar #(.P_CNT_W(P_CNT_W), .P_CODE_W(P_CODE_W)) i_sar (
		.clk_fb      (clk_fb),
		.rst_n       (rst_n),
		.sar_init    (sar_init),
		.sar_decide  (sar_decide),
		.fcal_cnt    (fcal_cnt),
		.fcal_target (fcal_target),
		.cal_code    (cal_code),
		.sar_last    (sar_last)
	);

endmodule

`default_nettype wire

// File: sim/mdll_fcal_asserts.sv
/*
 * concurrent checks on the calibration controller
 * request/acknowledge order, held ack and done strobe shape
 */
`timescale 1ns/100ps
`default_nettype none

module mdll_fcal_asserts (
	input wire                        clk_fb,
	input wire                        rst_n,
	input wire                        fcal_en,
	input wire                        fcal_start,
	input wire                        fcal_ready,
	input wire                        cal_busy,
	input wire                        cal_done,
	input wire mdll_pkg::fcal_state_t state
);

	import mdll_pkg::*;

	// new request only once the old ack is gone
	a_start_rise: assert property (@(posedge clk_fb) disable iff (!rst_n)
		$rose(fcal_start) |-> !fcal_ready)
		else $error("fcal_start rose while fcal_ready was high");

	// request drops after the ack, an abort is exempt
	a_start_fall: assert property (@(posedge clk_fb) disable iff (!rst_n || !fcal_en)
		$fell(fcal_start) |-> $past(fcal_ready))
		else $error("fcal_start fell before fcal_ready was seen");

	a_done_pulse: assert property (@(posedge clk_fb) disable iff (!rst_n)
		cal_done |=> !cal_done)
		else $error("cal_done held longer than one cycle");

	a_done_idle: assert property (@(posedge clk_fb) disable iff (!rst_n)
		cal_done |-> !cal_busy)
		else $error("cal_busy high together with cal_done");

	// count stays latched while the sar decides
	a_decide_ready: assert property (@(posedge clk_fb) disable iff (!rst_n)
		state == DECIDE |-> fcal_ready)
		else $error("fcal_ready low while the controller was in DECIDE");

endmodule

bind mdll_fcal_ctrl mdll_fcal_asserts i_asserts (
	.clk_fb     (clk_fb),
	.rst_n      (rst_n),
	.fcal_en    (fcal_en),
	.fcal_start (fcal_start),
	.fcal_ready (fcal_ready),
	.cal_busy   (cal_busy),
	.cal_done   (cal_done),
	.state      (state)
);

`default_nettype wire

// File: sim/tb_mdll_fcal.sv
/*
 * testbench for the coarse frequency calibration loop
 * clocks with oscillator model, lfsr stimulus, sar reference model
 * compare tasks and watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mdll_fcal;

	import mdll_pkg::*;

	localparam logic [31:0] SEED     = 32'd99572;
	localparam int          OSC_BASE = 10;  // ref period at code 0, ns
	localparam real         REF_STEP = 0.5; // ref half-period per code step, ns
	localparam int          NUM_CAL  = 12;
	// worst trial is about two pulse periods at ndiv 9 and code 63, doubled
	localparam int WATCHDOG_NS = (NUM_CAL + 1) * N_CODE * 2 * (2 ** 9) * 73 * 2;

	logic                  clk_fb;
	logic                  clk_refp;
	logic                  rst_n;
	logic                  en_fcal;
	logic                  cal_start;
	logic [N_NDIV-1:0]     fcal_ndiv_ref;
	logic [N_FCAL_CNT-1:0] fcal_target;
	logic [N_CODE-1:0]     cal_code;
	logic                  cal_busy;
	logic                  cal_done;
	logic [N_FCAL_CNT-1:0] fcal_cnt;
	logic                  fcal_ready;
	logic [31:0]           lfsr_state;

	mdll_fcal_top #(.P_CNT_W(N_FCAL_CNT), .P_CODE_W(N_CODE)) i_dut (.*);

	always #5 clk_fb = ~clk_fb;
	// oscillator stand-in, ref period scales with the code instead of clk_fb
	always #(REF_STEP * (OSC_BASE + cal_code)) clk_refp = ~clk_refp;

	// --------------------------------------------------
	// stimulus and reference model
	// --------------------------------------------------

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			v = (v << 1) | lfsr_state[0];
		end
	endtask

	// nominal count times ten, 2**ndiv ref cycles of (10 + code) ns in 10 ns units
	function automatic int nominal_x10(input int ndiv, input int code);
		return (1 << ndiv) * (OSC_BASE + code);
	endfunction

	// largest code whose nominal count fits the target
	function automatic logic [N_CODE-1:0] best_code(input int ndiv, input int target);
		logic [N_CODE-1:0] best;
		best = '0;
		for (int c = 0; c < 2 ** N_CODE; c++) begin
			if (nominal_x10(ndiv, c) <= 10 * target) best = N_CODE'(c);
		end
		return best;
	endfunction

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	task automatic fail_now(input string what);
		$display("%0t ns: %s", $time, what);
		$display("STATUS: FAIL");
		$fatal(1, "testbench check failed");
	endtask

	task automatic check_code(input string name, input logic [N_CODE-1:0] exp_val,
			input logic [N_CODE-1:0] act);
		if (act !== exp_val) begin
			$display("Mismatch at %0t ns: %s expected %0d, actual %0d", $time, name, exp_val, act);
			$display("STATUS: FAIL");
			$fatal(1, "code mismatch");
		end
	endtask

	task automatic check_cnt(input string name, input logic [N_FCAL_CNT-1:0] exp_val,
			input logic [N_FCAL_CNT-1:0] act, input int tol);
		int diff;
		diff = int'(act) - int'(exp_val);
		if (diff > tol || diff < -tol) begin
			$display("Mismatch at %0t ns: %s expected %0d +/- %0d, actual %0d",
				$time, name, exp_val, tol, act);
			$display("STATUS: FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp_val, input logic act);
		if (act !== exp_val) begin
			$display("Mismatch at %0t ns: %s expected %0b, actual %0b", $time, name, exp_val, act);
			$display("STATUS: FAIL");
			$fatal(1, "flag mismatch");
		end
	endtask

	// start just after a ref pulse fall, so the first trial pulse is all at the new code
	task automatic wait_ref_low();
		logic prev;
		logic cur;
		@(negedge clk_fb);
		cur = i_dut.i_counter.ref_pulse;
		do begin
			prev = cur;
			@(negedge clk_fb);
			cur = i_dut.i_counter.ref_pulse;
		end while (!(prev && !cur));
	endtask

	// one calibration, target half way between codes k and k+1
	task automatic run_calibration(input int ndiv, input int k, input bit abort_mid);
		logic [N_FCAL_CNT-1:0] target;
		logic [N_CODE-1:0]     exp_code; // model trial code
		logic [N_CODE-1:0]     trial;    // model one-hot pointer
		logic                  ready_q;
		logic                  busy_q;
		int                    n_meas;
		int                    r;
		target = N_FCAL_CNT'(((1 << ndiv) * (2 * (OSC_BASE + k) + 1)) / 20);
		@(posedge clk_fb);
		fcal_ndiv_ref <= N_NDIV'(ndiv);
		fcal_target   <= target;
		wait_ref_low();
		@(posedge clk_fb);
		cal_start <= 1'b1;
		@(posedge clk_fb);
		cal_start <= 1'b0;
		exp_code = {1'b1, {(N_CODE-1){1'b0}}}; // msb trial first
		trial    = exp_code;
		ready_q  = 1'b0;
		busy_q   = 1'b0;
		n_meas   = 0;
		forever begin
			@(posedge clk_fb);
			draw_bits(3, r);
			cal_start <= busy_q && (r == 0); // stray strobe while busy
			@(negedge clk_fb);
			busy_q = cal_busy;
			if (fcal_ready && !ready_q) begin
				check_code("cal_code", exp_code, cal_code);
				check_cnt("fcal_cnt", N_FCAL_CNT'((nominal_x10(ndiv, exp_code) + 5) / 10),
					fcal_cnt, 2);
				n_meas++;
				if (nominal_x10(ndiv, exp_code) > 10 * target) exp_code &= ~trial; // too slow
				trial = trial >> 1;
				exp_code |= trial;
				if (abort_mid && n_meas == 2) break;
			end
			ready_q = fcal_ready;
			if (cal_done) begin
				if (n_meas != N_CODE) fail_now("cal_done came before every code bit was measured");
				check_flag("cal_busy", 1'b0, cal_busy);
				check_code("cal_code", exp_code, cal_code);
				check_code("cal_code", best_code(ndiv, target), cal_code);
				break;
			end
		end
		@(posedge clk_fb);
		cal_start <= 1'b0;
		if (abort_mid) begin
			en_fcal <= 1'b0; // pull the enable mid search
			do begin
				@(negedge clk_fb);
				check_flag("cal_done", 1'b0, cal_done);
			end while (cal_busy || fcal_ready);
			@(posedge clk_fb);
			en_fcal <= 1'b1;
			repeat (4) @(posedge clk_fb); // enable sync settles
		end
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		int ndiv;
		int k;
		clk_fb        = 1'b0;
		clk_refp      = 1'b0;
		rst_n         = 1'b0;
		en_fcal       = 1'b0;
		cal_start     = 1'b0;
		fcal_ndiv_ref = '0;
		fcal_target   = '0;
		lfsr_state    = SEED;
		repeat (3) @(posedge clk_fb);
		rst_n <= 1'b1;
		repeat (20) begin // quiet after reset
			@(negedge clk_fb);
			check_flag("cal_busy", 1'b0, cal_busy);
			check_flag("cal_done", 1'b0, cal_done);
			check_flag("fcal_ready", 1'b0, fcal_ready);
			check_code("cal_code", '0, cal_code);
			check_cnt("fcal_cnt", '0, fcal_cnt, 0);
		end
		@(posedge clk_fb);
		en_fcal <= 1'b1;
		repeat (4) @(posedge clk_fb);
		for (int i = 0; i < NUM_CAL; i++) begin
			draw_bits(2, ndiv);
			ndiv = ndiv + 6; // 6..9, code step of 6.4 counts or more
			draw_bits(N_CODE, k);
			if (i == 0) k = 0;
			if (i == 1) k = 2 ** N_CODE - 1;
			if (i == 4) run_calibration(ndiv, k, 1'b1); // abort run first
			run_calibration(ndiv, k, 1'b0);
		end
		$display("STATUS: PASS");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the calibrations did not finish within %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: vlog.f
design/mdll_pkg.sv
design/mdll_synchronizer.sv
design/mdll_freq_div_radix2.sv
design/mdll_fcal_counter.sv
design/mdll_fcal_sar.sv
design/mdll_fcal_ctrl.sv
design/mdll_fcal_top.sv
sim/mdll_fcal_asserts.sv
sim/tb_mdll_fcal.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the calibration loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mdll_fcal -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_mdll_fcal > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
